//--- hdl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // datapath and history sizes
    localparam int XLEN    = 32;
    localparam int GHIST_W = 16;
    localparam int CNT_W   = 32;

    // bimodal table, indexed by pc[9:1]
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = 9;

    // tagged tables T0 and T1
    localparam int TAGE_ENTRIES  = 256;
    localparam int TAGE_IDX_W    = 8;
    localparam int TAGE_TAG_W    = 10;
    // upper tag bits that take part in the hit compare
    localparam int PARTIAL_TAG_W = 6;

    // btb, indexed by pc[9:2], tagged by pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_TAG_W   = 22;

    // rv32 opcodes handled by the decoder
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef struct packed {
        logic [TAGE_TAG_W-1:0] tag;
        logic [1:0]            ctr;
    } tage_entry_t;

    typedef struct packed {
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic               is_ctrl;
        logic               taken;
        logic [XLEN-1:0]    next_pc;
        logic [GHIST_W-1:0] hist;
        provider_e          provider;
        logic               btb_hit;
    } pred_t;

    // hist and provider come back exactly as they left in pred_t
    typedef struct packed {
        logic               valid;
        logic [XLEN-1:0]    pc;
        logic               taken;
        logic               correct;
        logic [XLEN-1:0]    target;
        logic [GHIST_W-1:0] hist;
        provider_e          provider;
    } resolve_t;

    // counter register map, word address is wb_adr[4:2]
    localparam int         NUM_REGS        = 7;
    localparam logic [2:0] REG_TOTAL       = 3'd0;
    localparam logic [2:0] REG_CORRECT     = 3'd1;
    localparam logic [2:0] REG_BIM_CORRECT = 3'd2;
    localparam logic [2:0] REG_T0_CORRECT  = 3'd3;
    localparam logic [2:0] REG_T1_CORRECT  = 3'd4;
    localparam logic [2:0] REG_BTB_HIT     = 3'd5;
    localparam logic [2:0] REG_BTB_MISS    = 3'd6;

endpackage

`default_nettype wire

//--- hdl/tagged_table.sv
`timescale 1ns/1ns
`default_nettype none

module tagged_table #(
    parameter type entry_t = logic,
    parameter int  ENTRIES = 256
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [$clog2(ENTRIES)-1:0] rd_idx_i,
    output logic                       rd_valid_o,
    output entry_t                     rd_entry_o,
    input  wire                        wr_en_i,
    input  wire  [$clog2(ENTRIES)-1:0] wr_idx_i,
    input  entry_t                     wr_entry_i
);

    entry_t             mem [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    // payload array, no reset
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= wr_entry_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

    // asynchronous read for same-cycle prediction
    assign rd_valid_o = valid_q[rd_idx_i];
    assign rd_entry_o = mem[rd_idx_i];

endmodule

`default_nettype wire

//--- hdl/tage_direction.sv
`timescale 1ns/1ns
`default_nettype none

module tage_direction (
    input  wire                           clk,
    input  wire                           rst,
    input  bpu_pkg::fetch_t               fetch_i,
    input  bpu_pkg::resolve_t             resolve_i,
    output logic                          taken_o,
    output logic [bpu_pkg::GHIST_W-1:0]   hist_o,
    output bpu_pkg::provider_e            provider_o
);

    typedef struct packed {
        logic [bpu_pkg::TAGE_IDX_W-1:0] t0_idx;
        logic [bpu_pkg::TAGE_TAG_W-1:0] t0_tag;
        logic [bpu_pkg::TAGE_IDX_W-1:0] t1_idx;
        logic [bpu_pkg::TAGE_TAG_W-1:0] t1_tag;
    } hash_t;

    localparam int TAG_HI = bpu_pkg::TAGE_TAG_W - 1;
    localparam int TAG_LO = bpu_pkg::TAGE_TAG_W - bpu_pkg::PARTIAL_TAG_W;

    // same hashes at fetch and at resolve
    function automatic hash_t tage_hash(input logic [bpu_pkg::XLEN-1:0] pc,
                                        input logic [bpu_pkg::GHIST_W-1:0] h);
        hash_t r;
        r.t0_idx = pc[7:0] ^ h[7:0];
        r.t0_tag = pc[17:8] ^ h[15:6];
        r.t1_idx = pc[7:0] ^ h[15:8];
        r.t1_tag = pc[17:8] ^ {2'b00, h[7:0]};
        return r;
    endfunction

    function automatic logic [1:0] sat_ctr(input logic [1:0] c, input logic up);
        logic [1:0] n;
        n = c;
        if (up && c != 2'b11) begin
            n = c + 2'd1;
        end else if (!up && c != 2'b00) begin
            n = c - 2'd1;
        end
        return n;
    endfunction

    logic [bpu_pkg::GHIST_W-1:0] ghist;
    logic [1:0]                  bim [bpu_pkg::BIM_ENTRIES];

    // write-side copy of the tagged tables, keeps the fetch read port free
    bpu_pkg::tage_entry_t              t0_shadow [bpu_pkg::TAGE_ENTRIES];
    bpu_pkg::tage_entry_t              t1_shadow [bpu_pkg::TAGE_ENTRIES];
    logic [bpu_pkg::TAGE_ENTRIES-1:0]  t0_vld;
    logic [bpu_pkg::TAGE_ENTRIES-1:0]  t1_vld;

    hash_t                          fh;
    hash_t                          rh;
    logic [bpu_pkg::BIM_IDX_W-1:0]  f_bim_idx;
    logic [bpu_pkg::BIM_IDX_W-1:0]  r_bim_idx;
    logic                           t0_rd_valid;
    logic                           t1_rd_valid;
    bpu_pkg::tage_entry_t           t0_rd;
    bpu_pkg::tage_entry_t           t1_rd;
    logic                           t0_hit;
    logic                           t1_hit;
    bpu_pkg::tage_entry_t           t0_old;
    bpu_pkg::tage_entry_t           t1_old;
    logic                           t0_wr_en;
    logic                           t1_wr_en;
    bpu_pkg::tage_entry_t           t0_wr;
    bpu_pkg::tage_entry_t           t1_wr;

    assign fh        = tage_hash(fetch_i.pc, ghist);
    assign rh        = tage_hash(resolve_i.pc, resolve_i.hist);
    assign f_bim_idx = fetch_i.pc[9:1];
    assign r_bim_idx = resolve_i.pc[9:1];

    tagged_table #(
        .entry_t (bpu_pkg::tage_entry_t),
        .ENTRIES (bpu_pkg::TAGE_ENTRIES)
    ) t0_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fh.t0_idx),
        .rd_valid_o (t0_rd_valid),
        .rd_entry_o (t0_rd),
        .wr_en_i    (t0_wr_en),
        .wr_idx_i   (rh.t0_idx),
        .wr_entry_i (t0_wr)
    );

    tagged_table #(
        .entry_t (bpu_pkg::tage_entry_t),
        .ENTRIES (bpu_pkg::TAGE_ENTRIES)
    ) t1_table (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fh.t1_idx),
        .rd_valid_o (t1_rd_valid),
        .rd_entry_o (t1_rd),
        .wr_en_i    (t1_wr_en),
        .wr_idx_i   (rh.t1_idx),
        .wr_entry_i (t1_wr)
    );

    // partial tag hit, longest history wins
    assign t0_hit = t0_rd_valid && (t0_rd.tag[TAG_HI:TAG_LO] == fh.t0_tag[TAG_HI:TAG_LO]);
    assign t1_hit = t1_rd_valid && (t1_rd.tag[TAG_HI:TAG_LO] == fh.t1_tag[TAG_HI:TAG_LO]);

    always_comb begin
        if (t1_hit) begin
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = t1_rd.ctr[1];
        end else if (t0_hit) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = t0_rd.ctr[1];
        end else begin
            provider_o = bpu_pkg::PROV_BIMODAL;
            taken_o    = bim[f_bim_idx][1];
        end
    end

    assign hist_o = ghist;

    assign t0_old = t0_shadow[rh.t0_idx];
    assign t1_old = t1_shadow[rh.t1_idx];

    // tagged table update policy, at most one write per table
    always_comb begin
        t0_wr_en = 1'b0;
        t1_wr_en = 1'b0;
        t0_wr    = t0_old;
        t1_wr    = t1_old;
        if (resolve_i.valid) begin
            if (resolve_i.correct) begin
                if (resolve_i.provider == bpu_pkg::PROV_T0) begin
                    t0_wr_en  = 1'b1;
                    t0_wr.ctr = sat_ctr(t0_old.ctr, resolve_i.taken);
                end else if (resolve_i.provider == bpu_pkg::PROV_T1) begin
                    t1_wr_en  = 1'b1;
                    t1_wr.ctr = sat_ctr(t1_old.ctr, resolve_i.taken);
                end
            end else if (resolve_i.provider == bpu_pkg::PROV_T0) begin
                t0_wr_en  = 1'b1;
                t0_wr.ctr = resolve_i.taken ? 2'b11 : 2'b00;
            end else if (resolve_i.provider == bpu_pkg::PROV_T1) begin
                t1_wr_en  = 1'b1;
                t1_wr.ctr = resolve_i.taken ? 2'b11 : 2'b00;
            end else if (!t1_vld[rh.t1_idx] || t1_old.tag != rh.t1_tag) begin
                // bimodal miss, allocate T1 first
                t1_wr_en  = 1'b1;
                t1_wr.tag = rh.t1_tag;
                t1_wr.ctr = resolve_i.taken ? 2'b10 : 2'b01;
            end else if (!t0_vld[rh.t0_idx] || t0_old.tag != rh.t0_tag) begin
                t0_wr_en  = 1'b1;
                t0_wr.tag = rh.t0_tag;
                t0_wr.ctr = resolve_i.taken ? 2'b10 : 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (t0_wr_en) begin
            t0_shadow[rh.t0_idx] <= t0_wr;
        end
        if (t1_wr_en) begin
            t1_shadow[rh.t1_idx] <= t1_wr;
        end
    end

    // history shifts only at resolve
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist  <= '0;
            t0_vld <= '0;
            t1_vld <= '0;
        end else begin
            if (resolve_i.valid) begin
                ghist <= {ghist[bpu_pkg::GHIST_W-2:0], resolve_i.taken};
            end
            if (t0_wr_en) begin
                t0_vld[rh.t0_idx] <= 1'b1;
            end
            if (t1_wr_en) begin
                t1_vld[rh.t1_idx] <= 1'b1;
            end
        end
    end

    // bimodal counters start weak not-taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
                bim[i] <= 2'b01;
            end
        end else if (resolve_i.valid) begin
            bim[r_bim_idx] <= sat_ctr(bim[r_bim_idx], resolve_i.taken);
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_target.sv
`timescale 1ns/1ns
`default_nettype none

module branch_target (
    input  wire                           clk,
    input  wire                           rst,
    input  bpu_pkg::fetch_t               fetch_i,
    input  bpu_pkg::resolve_t             resolve_i,
    input  wire                           taken_raw_i,
    input  wire  [bpu_pkg::GHIST_W-1:0]   hist_i,
    input  bpu_pkg::provider_e            provider_i,
    output bpu_pkg::pred_t                pred_o
);

    logic [6:0]               opcode;
    logic                     is_branch;
    logic                     is_jal;
    logic [bpu_pkg::XLEN-1:0] imm_b;
    logic [bpu_pkg::XLEN-1:0] imm_j;
    logic [bpu_pkg::XLEN-1:0] offset;
    logic                     taken;
    logic                     btb_valid;
    logic                     btb_hit;
    bpu_pkg::btb_entry_t      btb_rd;
    logic                     btb_wr_en;
    bpu_pkg::btb_entry_t      btb_wr;

    assign opcode    = fetch_i.inst[6:0];
    assign is_branch = (opcode == bpu_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == bpu_pkg::OPC_JAL);

    // B and J immediates, sign extended
    assign imm_b = {{20{fetch_i.inst[31]}}, fetch_i.inst[7], fetch_i.inst[30:25],
                    fetch_i.inst[11:8], 1'b0};
    assign imm_j = {{12{fetch_i.inst[31]}}, fetch_i.inst[19:12], fetch_i.inst[20],
                    fetch_i.inst[30:21], 1'b0};
    assign offset = is_jal ? imm_j : imm_b;

    tagged_table #(
        .entry_t (bpu_pkg::btb_entry_t),
        .ENTRIES (bpu_pkg::BTB_ENTRIES)
    ) btb (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_i.pc[9:2]),
        .rd_valid_o (btb_valid),
        .rd_entry_o (btb_rd),
        .wr_en_i    (btb_wr_en),
        .wr_idx_i   (resolve_i.pc[9:2]),
        .wr_entry_i (btb_wr)
    );

    // full tag compare on the btb
    assign btb_hit = btb_valid && (btb_rd.tag == fetch_i.pc[31:10]);

    // only taken resolves fill the btb
    assign btb_wr_en     = resolve_i.valid && resolve_i.taken;
    assign btb_wr.tag    = resolve_i.pc[31:10];
    assign btb_wr.target = resolve_i.target;

    // jal always taken, non-control never
    assign taken = is_jal || (is_branch && taken_raw_i);

    always_comb begin
        pred_o.is_ctrl  = is_branch || is_jal;
        pred_o.taken    = taken;
        pred_o.hist     = hist_i;
        pred_o.provider = provider_i;
        pred_o.btb_hit  = btb_hit;
        if (!taken) begin
            pred_o.next_pc = fetch_i.pc + 32'd4;
        end else if (btb_hit) begin
            pred_o.next_pc = btb_rd.target;
        end else begin
            pred_o.next_pc = fetch_i.pc + offset;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bpu_perf_wb.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_perf_wb (
    input  wire                         clk,
    input  wire                         rst,
    input  bpu_pkg::fetch_t             fetch_i,
    input  bpu_pkg::pred_t              pred_i,
    input  bpu_pkg::resolve_t           resolve_i,
    input  wire                         wb_cyc_i,
    input  wire                         wb_stb_i,
    input  wire                         wb_we_i,
    input  wire  [bpu_pkg::XLEN-1:0]    wb_adr_i,
    input  wire  [bpu_pkg::XLEN-1:0]    wb_dat_i,
    output logic [bpu_pkg::XLEN-1:0]    wb_dat_o,
    output logic                        wb_ack_o
);

    logic [bpu_pkg::CNT_W-1:0] cnt [bpu_pkg::NUM_REGS];
    logic [2:0]                reg_sel;
    logic                      req;
    logic                      clr;
    logic                      btb_event;
    logic [2:0]                prov_sel;

    assign reg_sel = wb_adr_i[4:2];
    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    // write data is ignored, any write clears
    assign clr     = wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o;

    assign btb_event = fetch_i.valid && pred_i.is_ctrl && pred_i.taken;
    assign prov_sel  = bpu_pkg::REG_BIM_CORRECT + {1'b0, resolve_i.provider};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < bpu_pkg::NUM_REGS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            wb_ack_o <= req;
            if (clr) begin
                // events in the clearing cycle are lost
                for (int i = 0; i < bpu_pkg::NUM_REGS; i++) begin
                    cnt[i] <= '0;
                end
            end else begin
                if (resolve_i.valid) begin
                    cnt[bpu_pkg::REG_TOTAL] <= cnt[bpu_pkg::REG_TOTAL] + 1'b1;
                    if (resolve_i.correct) begin
                        cnt[bpu_pkg::REG_CORRECT] <= cnt[bpu_pkg::REG_CORRECT] + 1'b1;
                        cnt[prov_sel] <= cnt[prov_sel] + 1'b1;
                    end
                end
                if (btb_event) begin
                    if (pred_i.btb_hit) begin
                        cnt[bpu_pkg::REG_BTB_HIT] <= cnt[bpu_pkg::REG_BTB_HIT] + 1'b1;
                    end else begin
                        cnt[bpu_pkg::REG_BTB_MISS] <= cnt[bpu_pkg::REG_BTB_MISS] + 1'b1;
                    end
                end
            end
        end
    end

    // read mux, address 7 reads as zero
    always_comb begin
        if (reg_sel < 3'(bpu_pkg::NUM_REGS)) begin
            wb_dat_o = cnt[reg_sel];
        end else begin
            wb_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_top (
    input  wire                         clk,
    input  wire                         rst,
    input  bpu_pkg::fetch_t             fetch_i,
    input  bpu_pkg::resolve_t           resolve_i,
    output bpu_pkg::pred_t              pred_o,
    input  wire                         wb_cyc_i,
    input  wire                         wb_stb_i,
    input  wire                         wb_we_i,
    input  wire  [bpu_pkg::XLEN-1:0]    wb_adr_i,
    input  wire  [bpu_pkg::XLEN-1:0]    wb_dat_i,
    output logic [bpu_pkg::XLEN-1:0]    wb_dat_o,
    output logic                        wb_ack_o
);

    logic                        taken_raw;
    logic [bpu_pkg::GHIST_W-1:0] hist;
    bpu_pkg::provider_e          provider;

    tage_direction u_tage_direction (
        .clk        (clk),
        .rst        (rst),
        .fetch_i    (fetch_i),
        .resolve_i  (resolve_i),
        .taken_o    (taken_raw),
        .hist_o     (hist),
        .provider_o (provider)
    );

    branch_target u_branch_target (
        .clk         (clk),
        .rst         (rst),
        .fetch_i     (fetch_i),
        .resolve_i   (resolve_i),
        .taken_raw_i (taken_raw),
        .hist_i      (hist),
        .provider_i  (provider),
        .pred_o      (pred_o)
    );

    bpu_perf_wb u_bpu_perf_wb (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch_i),
        .pred_i    (pred_o),
        .resolve_i (resolve_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/bpu_assert.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_assert (
    input  wire                clk,
    input  wire                rst,
    input  bpu_pkg::fetch_t    fetch_i,
    input  bpu_pkg::pred_t     pred_i,
    input  wire                wb_cyc_i,
    input  wire                wb_stb_i,
    input  wire                wb_ack_i
);

    int error_count = 0;

    // ack only answers a live request
    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
        else begin
            error_count++;
            $error("wishbone ack rose without cyc and stb");
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack_i |=> !wb_ack_i)
        else begin
            error_count++;
            $error("wishbone ack held for more than one cycle");
        end

    taken_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_i.taken |-> pred_i.is_ctrl)
        else begin
            error_count++;
            $error("prediction taken on a non-control instruction");
        end

    // sequential fetch for anything that is not a branch or jal
    plain_next_pc: assert property (@(posedge clk) disable iff (rst)
        !pred_i.is_ctrl |-> pred_i.next_pc == fetch_i.pc + 32'd4)
        else begin
            error_count++;
            $error("non-control next_pc is not pc+4");
        end

endmodule

`default_nettype wire

//--- testbench/bpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_tb;

    localparam int NUM_TXN     = 3000;
    localparam int CLK_NS      = 40;
    localparam int WATCHDOG_NS = (NUM_TXN * 2 + 400) * CLK_NS;
    localparam int ACK_LIMIT   = 16;

    logic              clk;
    logic              rst;
    bpu_pkg::fetch_t   fetch;
    bpu_pkg::resolve_t resolve;
    bpu_pkg::pred_t    pred;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [31:0]       wb_adr;
    logic [31:0]       wb_dat_w;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;
    logic [15:0]       lfsr_state;
    logic [31:0]       rd_data;
    int                mismatch_count;
    int                other_count;

    // reference model state
    logic [15:0]          m_hist;
    logic [1:0]           m_bim [bpu_pkg::BIM_ENTRIES];
    bpu_pkg::tage_entry_t m_t0 [bpu_pkg::TAGE_ENTRIES];
    bpu_pkg::tage_entry_t m_t1 [bpu_pkg::TAGE_ENTRIES];
    bpu_pkg::btb_entry_t  m_btb [bpu_pkg::BTB_ENTRIES];
    logic [255:0]         m_t0_vld;
    logic [255:0]         m_t1_vld;
    logic [255:0]         m_btb_vld;
    logic [31:0]          m_cnt [bpu_pkg::NUM_REGS];

    tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) u_clock (.clk_o(clk), .rst_o(rst));

    bpu_top dut (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch),
        .resolve_i (resolve),
        .pred_o    (pred),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_adr_i  (wb_adr),
        .wb_dat_i  (wb_dat_w),
        .wb_dat_o  (wb_dat_r),
        .wb_ack_o  (wb_ack)
    );

    bind bpu_top bpu_assert u_bpu_assert (
        .clk      (clk),
        .rst      (rst),
        .fetch_i  (fetch_i),
        .pred_i   (pred_o),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_i (wb_ack_o)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // fields holds rs2, rs1 and funct3
    function automatic logic [31:0] branch_encoding(input logic [12:0] imm,
                                                    input logic [12:0] fields);
        return {imm[12], imm[10:5], fields, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_encoding(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic tagged_hash(input logic [31:0] pc, input logic [15:0] h,
                               output logic [7:0] i0, output logic [9:0] g0,
                               output logic [7:0] i1, output logic [9:0] g1);
        i0 = pc[7:0] ^ h[7:0];
        g0 = pc[17:8] ^ h[15:6];
        i1 = pc[7:0] ^ h[15:8];
        g1 = pc[17:8] ^ {2'b00, h[7:0]};
    endtask

    task automatic predict_direction(input logic [31:0] pc, output bpu_pkg::provider_e prov,
                                     output logic taken);
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] g0;
        logic [9:0] g1;
        tagged_hash(pc, m_hist, i0, g0, i1, g1);
        if (m_t1_vld[i1] && m_t1[i1].tag[9:4] == g1[9:4]) begin
            prov  = bpu_pkg::PROV_T1;
            taken = m_t1[i1].ctr[1];
        end else if (m_t0_vld[i0] && m_t0[i0].tag[9:4] == g0[9:4]) begin
            prov  = bpu_pkg::PROV_T0;
            taken = m_t0[i0].ctr[1];
        end else begin
            prov  = bpu_pkg::PROV_BIMODAL;
            taken = m_bim[pc[9:1]][1];
        end
    endtask

    task automatic apply_resolve(input logic [31:0] pc, input logic taken, input logic correct,
                                 input logic [31:0] target, input bpu_pkg::provider_e prov);
        logic [7:0] i0;
        logic [7:0] i1;
        logic [9:0] g0;
        logic [9:0] g1;
        tagged_hash(pc, m_hist, i0, g0, i1, g1);
        m_cnt[bpu_pkg::REG_TOTAL]++;
        if (correct) begin
            m_cnt[bpu_pkg::REG_CORRECT]++;
            case (prov)
                bpu_pkg::PROV_T0: begin
                    m_cnt[bpu_pkg::REG_T0_CORRECT]++;
                    m_t0[i0].ctr = saturate(m_t0[i0].ctr, taken);
                end
                bpu_pkg::PROV_T1: begin
                    m_cnt[bpu_pkg::REG_T1_CORRECT]++;
                    m_t1[i1].ctr = saturate(m_t1[i1].ctr, taken);
                end
                default: m_cnt[bpu_pkg::REG_BIM_CORRECT]++;
            endcase
        end else if (prov == bpu_pkg::PROV_T0) begin
            m_t0[i0].ctr = taken ? 2'd3 : 2'd0;
        end else if (prov == bpu_pkg::PROV_T1) begin
            m_t1[i1].ctr = taken ? 2'd3 : 2'd0;
        end else if (!m_t1_vld[i1] || m_t1[i1].tag != g1) begin
            m_t1[i1].tag = g1;
            m_t1[i1].ctr = taken ? 2'd2 : 2'd1;
            m_t1_vld[i1] = 1'b1;
        end else if (!m_t0_vld[i0] || m_t0[i0].tag != g0) begin
            m_t0[i0].tag = g0;
            m_t0[i0].ctr = taken ? 2'd2 : 2'd1;
            m_t0_vld[i0] = 1'b1;
        end
        m_bim[pc[9:1]] = saturate(m_bim[pc[9:1]], taken);
        if (taken) begin
            m_btb[pc[9:2]].tag    = pc[31:10];
            m_btb[pc[9:2]].target = target;
            m_btb_vld[pc[9:2]]    = 1'b1;
        end
        m_hist = {m_hist[14:0], taken};
    endtask

    // one fetch cycle followed by one resolve cycle
    task automatic run_transaction();
        logic [3:0]         slot;
        logic [1:0]         kind;
        logic [31:0]        pc;
        logic [31:0]        inst;
        logic [31:0]        imm;
        logic [31:0]        target;
        logic [31:0]        exp_next;
        logic [12:0]        bimm;
        logic [20:0]        jimm;
        logic               is_branch;
        logic               is_jal;
        logic               raw;
        logic               pred_taken;
        logic               actual;
        logic               btb_hit;
        logic [7:0]         bidx;
        bpu_pkg::provider_e prov;

        slot      = 4'(random_bits(4));
        kind      = 2'(random_bits(2));
        is_jal    = (kind == 2'd1);
        is_branch = kind[1];
        // four tags share each btb index
        pc = 32'h0004_1000 + (32'(slot[3:2]) << 10) + (32'(slot[1:0]) << 2);
        if (is_branch) begin
            bimm = {12'(random_bits(12)), 1'b0};
            imm  = {{19{bimm[12]}}, bimm};
            inst = branch_encoding(bimm, 13'(random_bits(13)));
        end else if (is_jal) begin
            jimm = {20'(random_bits(20)), 1'b0};
            imm  = {{11{jimm[20]}}, jimm};
            inst = jal_encoding(jimm, 5'(random_bits(5)));
        end else begin
            imm  = '0;
            inst = {25'(random_bits(25)), 7'b0010011};
        end

        predict_direction(pc, prov, raw);
        pred_taken = is_jal || (is_branch && raw);
        bidx       = pc[9:2];
        btb_hit    = m_btb_vld[bidx] && (m_btb[bidx].tag == pc[31:10]);
        if (!pred_taken) begin
            exp_next = pc + 32'd4;
        end else if (btb_hit) begin
            exp_next = m_btb[bidx].target;
        end else begin
            exp_next = pc + imm;
        end

        // upper slots follow the history and the rest are biased coins
        if (is_jal) begin
            actual = 1'b1;
        end else if (!is_branch) begin
            actual = 1'b0;
        end else if (slot[3]) begin
            actual = m_hist[slot[1:0]] ^ slot[2];
        end else if (slot[0]) begin
            actual = (2'(random_bits(2)) != 2'd0);
        end else begin
            actual = (2'(random_bits(2)) == 2'd0);
        end
        target = actual ? pc + imm : pc + 32'd4;

        @(posedge clk);
        fetch.valid   <= 1'b1;
        fetch.pc      <= pc;
        fetch.inst    <= inst;
        resolve.valid <= 1'b0;
        @(negedge clk);
        check_value("pred_o.is_ctrl", pred.is_ctrl, is_branch || is_jal);
        check_value("pred_o.taken", pred.taken, pred_taken);
        check_value("pred_o.next_pc", pred.next_pc, exp_next);
        check_value("pred_o.hist", pred.hist, m_hist);
        check_value("pred_o.btb_hit", pred.btb_hit, btb_hit);
        if (is_branch || is_jal) begin
            check_value("pred_o.provider", pred.provider, prov);
        end
        if (pred_taken) begin
            if (btb_hit) begin
                m_cnt[bpu_pkg::REG_BTB_HIT]++;
            end else begin
                m_cnt[bpu_pkg::REG_BTB_MISS]++;
            end
        end

        @(posedge clk);
        fetch.valid      <= 1'b0;
        resolve.valid    <= is_branch || is_jal;
        resolve.pc       <= pc;
        resolve.taken    <= actual;
        resolve.correct  <= (pred_taken == actual);
        resolve.target   <= target;
        resolve.hist     <= m_hist;
        resolve.provider <= prov;
        if (is_branch || is_jal) begin
            apply_resolve(pc, actual, pred_taken == actual, target, prov);
        end
    endtask

    task automatic bus_access(input logic we, input logic [2:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {27'd0, addr, 2'b00};
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (wb_ack) else begin
            other_count++;
            $display("wishbone access to register %0d was never acknowledged", addr);
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run stopped by the watchdog after %0d ns", WATCHDOG_NS);
        $display("errors: %0d value, %0d other, %0d assertion", mismatch_count, other_count,
                 dut.u_bpu_assert.error_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        fetch          = '0;
        resolve        = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        lfsr_state     = 16'd40475;
        mismatch_count = 0;
        other_count    = 0;
        m_hist         = '0;
        m_t0_vld       = '0;
        m_t1_vld       = '0;
        m_btb_vld      = '0;
        for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
            m_bim[i] = 2'd1;
        end
        for (int i = 0; i < bpu_pkg::NUM_REGS; i++) begin
            m_cnt[i] = '0;
        end

        @(negedge rst);
        for (int n = 0; n < NUM_TXN; n++) begin
            run_transaction();
        end
        @(posedge clk);
        resolve.valid <= 1'b0;

        for (int r = 0; r < 8; r++) begin
            bus_access(1'b0, 3'(r), '0, rd_data);
            check_value($sformatf("wb_dat_o reg %0d", r), rd_data,
                        (r < bpu_pkg::NUM_REGS) ? m_cnt[r] : 32'd0);
        end
        // any write clears every counter
        bus_access(1'b1, bpu_pkg::REG_TOTAL, random_bits(32), rd_data);
        for (int r = 0; r < bpu_pkg::NUM_REGS; r++) begin
            bus_access(1'b0, 3'(r), '0, rd_data);
            check_value($sformatf("wb_dat_o reg %0d after clear", r), rd_data, 32'd0);
        end

        $display("errors: %0d value, %0d other, %0d assertion", mismatch_count, other_count,
                 dut.u_bpu_assert.error_count);
        if (mismatch_count + other_count + dut.u_bpu_assert.error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/bpu_pkg.sv
hdl/tagged_table.sv
hdl/tage_direction.sv
hdl/branch_target.sv
hdl/bpu_perf_wb.sv
hdl/bpu_top.sv
testbench/tb_clock.sv
testbench/bpu_assert.sv
testbench/bpu_tb.sv

//--- Bender.yml
package:
  name: bpu

sources:
  # design
  - files:
      - hdl/bpu_pkg.sv
      - hdl/tagged_table.sv
      - hdl/tage_direction.sv
      - hdl/branch_target.sv
      - hdl/bpu_perf_wb.sv
      - hdl/bpu_top.sv

  # testbench, top module bpu_tb
  - target: simulation
    files:
      - testbench/tb_clock.sv
      - testbench/bpu_assert.sv
      - testbench/bpu_tb.sv
